//--- files.f
+incdir+testbench
hw/bpu_pkg.sv
hw/ras_pkg.sv
hw/ras_spec_ptr.sv
hw/ras_spec_stack.sv
hw/ras_commit_stack.sv
hw/ras_top.sv
testbench/ras_clock_gen.sv
testbench/ras_tb.sv

//--- hw/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    parameter int VADDR_WIDTH  = 32;
    parameter int INST_OFFSET  = 2;
    parameter int OFFSET_WIDTH = 3;

    // a call is one 4 byte instruction, so its return lands right after it
    parameter int RET_STEP = 4;

    typedef logic [VADDR_WIDTH-1:0] vaddr_t;

    // return address of a call sitting at slot offset within its fetch block
    function automatic vaddr_t call_ret_addr(input vaddr_t start_addr,
                                             input logic [OFFSET_WIDTH-1:0] offset);
        vaddr_t inst_addr;
        inst_addr = start_addr + (vaddr_t'(offset) << INST_OFFSET);
        return inst_addr + vaddr_t'(RET_STEP);
    endfunction

endpackage

`default_nettype wire

//--- hw/ras_commit_stack.sv
`timescale 1ns/1ps
`default_nettype none

module ras_commit_stack #(
    parameter int DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             commit_valid,
    input  ras_pkg::ras_op_e                 commit_op,
    input  bpu_pkg::vaddr_t                  commit_start_addr,
    input  logic [bpu_pkg::OFFSET_WIDTH-1:0] commit_offset,
    input  logic [$clog2(DEPTH)-1:0]         commit_raddr,
    output logic [$clog2(DEPTH)-1:0]         commit_top,
    output logic [$clog2(DEPTH+1)-1:0]       commit_count,
    output bpu_pkg::vaddr_t                  commit_rdata
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    bpu_pkg::vaddr_t  mem [DEPTH];
    logic [IDX_W-1:0] top_m1;
    logic [IDX_W-1:0] waddr;
    logic             we;
    bpu_pkg::vaddr_t  wdata;

    assign top_m1 = (commit_top == '0) ? IDX_W'(DEPTH - 1) : commit_top - 1'b1;

    // only retired calls write, and a pop_push replaces the entry it pops
    assign we    = commit_valid & ras_pkg::op_writes(commit_op);
    assign waddr = (commit_op == ras_pkg::op_pop_push) ? top_m1 : commit_top;
    assign wdata = bpu_pkg::call_ret_addr(commit_start_addr, commit_offset);

    assign commit_rdata = mem[commit_raddr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // committed state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_top   <= '0;
            commit_count <= '0;
        end else if (commit_valid) begin
            commit_top   <= IDX_W'(ras_pkg::next_top(int'(commit_top), int'(commit_count),
                                                     commit_op, DEPTH));
            commit_count <= CNT_W'(ras_pkg::next_count(int'(commit_count), commit_op, DEPTH));
        end
    end

endmodule

`default_nettype wire

//--- hw/ras_pkg.sv
`default_nettype none

package ras_pkg;

    // bit 1 marks a write to the stack, bit 0 marks a read of top minus one
    typedef enum logic [1:0] {
        op_none     = 2'b00,
        op_pop      = 2'b01,
        op_push     = 2'b10,
        op_pop_push = 2'b11
    } ras_op_e;

    function automatic logic op_writes(input ras_op_e op);
        return op[1];
    endfunction

    function automatic logic op_pops(input ras_op_e op);
        return op[0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checkpoint stepping, shared by both stacks and the model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int next_top(input int top, input int count, input ras_op_e op,
                                    input int depth);
        int nxt;
        nxt = top;
        if (op == op_push) begin
            nxt = (top == depth - 1) ? 0 : top + 1;
        end else if (op == op_pop && count != 0) begin
            nxt = (top == 0) ? depth - 1 : top - 1;
        end
        return nxt;
    endfunction

    // a push at full keeps the count and drops the oldest entry
    function automatic int next_count(input int count, input ras_op_e op, input int depth);
        int nxt;
        nxt = count;
        if (op == op_push && count != depth) begin
            nxt = count + 1;
        end else if (op == op_pop && count != 0) begin
            nxt = count - 1;
        end
        return nxt;
    endfunction

endpackage

`default_nettype wire

//--- hw/ras_spec_ptr.sv
`timescale 1ns/1ps
`default_nettype none

module ras_spec_ptr #(
    parameter int DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req_valid,
    input  ras_pkg::ras_op_e               req_op,
    input  bpu_pkg::vaddr_t                req_target,
    input  logic                           squash_valid,
    input  ras_pkg::ras_op_e               squash_op,
    input  logic [$clog2(DEPTH)-1:0]       squash_top,
    input  logic [$clog2(DEPTH+1)-1:0]     squash_count,
    input  bpu_pkg::vaddr_t                squash_start_addr,
    input  logic [bpu_pkg::OFFSET_WIDTH-1:0] squash_offset,
    input  logic                           flush,
    input  logic [$clog2(DEPTH)-1:0]       commit_top,
    input  logic [$clog2(DEPTH+1)-1:0]     commit_count,
    output logic [$clog2(DEPTH)-1:0]       ckpt_top,
    output logic [$clog2(DEPTH+1)-1:0]     ckpt_count,
    output logic                           not_empty,
    output logic                           spec_we,
    output logic [$clog2(DEPTH)-1:0]       spec_waddr,
    output bpu_pkg::vaddr_t                spec_wdata,
    output logic [$clog2(DEPTH)-1:0]       rd_addr,
    output logic                           rd_fire,
    output logic                           stale_all
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [IDX_W-1:0] top;
    logic [CNT_W-1:0] count;
    logic [IDX_W-1:0] top_m1;
    logic [IDX_W-1:0] squash_top_m1;
    logic             lookup_go;
    bpu_pkg::vaddr_t  squash_wdata;

    // the checkpoint is the state before this cycle's operation
    assign ckpt_top   = top;
    assign ckpt_count = count;
    assign not_empty  = (count != '0);

    assign top_m1        = (top == '0) ? IDX_W'(DEPTH - 1) : top - 1'b1;
    assign squash_top_m1 = (squash_top == '0) ? IDX_W'(DEPTH - 1) : squash_top - 1'b1;

    assign squash_wdata = bpu_pkg::call_ret_addr(squash_start_addr, squash_offset);

    // flush wins over squash, squash wins over a lookup
    assign lookup_go = req_valid & ~squash_valid & ~flush;
    assign rd_fire   = lookup_go & ras_pkg::op_pops(req_op) & not_empty;
    assign rd_addr   = top_m1;
    assign stale_all = flush;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write request to the storage stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        spec_we    = 1'b0;
        spec_waddr = top;
        spec_wdata = req_target;
        if (!flush) begin
            if (squash_valid) begin
                spec_we    = ras_pkg::op_writes(squash_op);
                spec_waddr = (squash_op == ras_pkg::op_pop_push) ? squash_top_m1 : squash_top;
                spec_wdata = squash_wdata;
            end else if (req_valid) begin
                spec_we    = ras_pkg::op_writes(req_op);
                spec_waddr = (req_op == ras_pkg::op_pop_push) ? top_m1 : top;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // speculative pointers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            top   <= '0;
            count <= '0;
        end else if (flush) begin
            top   <= commit_top;
            count <= commit_count;
        end else if (squash_valid) begin
            // restore the checkpoint, then replay the squashed instruction's op
            top   <= IDX_W'(ras_pkg::next_top(int'(squash_top), int'(squash_count),
                                              squash_op, DEPTH));
            count <= CNT_W'(ras_pkg::next_count(int'(squash_count), squash_op, DEPTH));
        end else if (req_valid) begin
            top   <= IDX_W'(ras_pkg::next_top(int'(top), int'(count), req_op, DEPTH));
            count <= CNT_W'(ras_pkg::next_count(int'(count), req_op, DEPTH));
        end
    end

    // count is loaded from squash and commit inputs too, not only stepped here
    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- hw/ras_spec_stack.sv
`timescale 1ns/1ps
`default_nettype none

module ras_spec_stack #(
    parameter int DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     spec_we,
    input  logic [$clog2(DEPTH)-1:0] spec_waddr,
    input  bpu_pkg::vaddr_t          spec_wdata,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    input  logic                     rd_fire,
    input  logic                     stale_all,
    input  bpu_pkg::vaddr_t          commit_rdata,
    output logic [$clog2(DEPTH)-1:0] commit_raddr,
    output logic                     predict_valid,
    output bpu_pkg::vaddr_t          predict_target
);

    bpu_pkg::vaddr_t  mem [DEPTH];
    logic [DEPTH-1:0] stale;
    bpu_pkg::vaddr_t  rd_data;

    // the commit copy of the same slot stands in for a stale entry
    assign commit_raddr = rd_addr;
    assign rd_data      = stale[rd_addr] ? commit_rdata : mem[rd_addr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage and stale tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (spec_we) begin
            mem[spec_waddr] <= spec_wdata;
        end
    end

    // after a flush every slot comes from the commit stack until pushed again
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stale <= '0;
        end else if (stale_all) begin
            stale <= '1;
        end else if (spec_we) begin
            stale[spec_waddr] <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registered prediction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            predict_valid <= 1'b0;
        end else begin
            predict_valid <= rd_fire;
        end
    end

    // sampled at the same edge as the write, so a pop_push sees the old value
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            predict_target <= rd_data;
        end
    end

    // a write in a flush cycle would leave its freshly written slot marked stale
    a_no_write_on_stale_all: assert property (@(posedge clk) disable iff (rst)
        stale_all |-> !spec_we);

endmodule

`default_nettype wire

//--- hw/ras_top.sv
`timescale 1ns/1ps
`default_nettype none

module ras_top #(
    parameter int DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req_valid,
    input  ras_pkg::ras_op_e                 req_op,
    input  bpu_pkg::vaddr_t                  req_target,
    input  logic                             squash_valid,
    input  ras_pkg::ras_op_e                 squash_op,
    input  logic [$clog2(DEPTH)-1:0]         squash_top,
    input  logic [$clog2(DEPTH+1)-1:0]       squash_count,
    input  bpu_pkg::vaddr_t                  squash_start_addr,
    input  logic [bpu_pkg::OFFSET_WIDTH-1:0] squash_offset,
    input  logic                             flush,
    input  logic                             commit_valid,
    input  ras_pkg::ras_op_e                 commit_op,
    input  bpu_pkg::vaddr_t                  commit_start_addr,
    input  logic [bpu_pkg::OFFSET_WIDTH-1:0] commit_offset,
    output logic [$clog2(DEPTH)-1:0]         ckpt_top,
    output logic [$clog2(DEPTH+1)-1:0]       ckpt_count,
    output logic                             not_empty,
    output logic                             predict_valid,
    output bpu_pkg::vaddr_t                  predict_target
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic             spec_we;
    logic [IDX_W-1:0] spec_waddr;
    bpu_pkg::vaddr_t  spec_wdata;
    logic [IDX_W-1:0] rd_addr;
    logic             rd_fire;
    logic             stale_all;
    logic [IDX_W-1:0] commit_top;
    logic [CNT_W-1:0] commit_count;
    logic [IDX_W-1:0] commit_raddr;
    bpu_pkg::vaddr_t  commit_rdata;

    // stage one, pointers and address generation
    ras_spec_ptr #(
        .DEPTH (DEPTH)
    ) u_ras_spec_ptr (
        .clk               (clk),
        .rst               (rst),
        .req_valid         (req_valid),
        .req_op            (req_op),
        .req_target        (req_target),
        .squash_valid      (squash_valid),
        .squash_op         (squash_op),
        .squash_top        (squash_top),
        .squash_count      (squash_count),
        .squash_start_addr (squash_start_addr),
        .squash_offset     (squash_offset),
        .flush             (flush),
        .commit_top        (commit_top),
        .commit_count      (commit_count),
        .ckpt_top          (ckpt_top),
        .ckpt_count        (ckpt_count),
        .not_empty         (not_empty),
        .spec_we           (spec_we),
        .spec_waddr        (spec_waddr),
        .spec_wdata        (spec_wdata),
        .rd_addr           (rd_addr),
        .rd_fire           (rd_fire),
        .stale_all         (stale_all)
    );

    // stage two, storage read and prediction register
    ras_spec_stack #(
        .DEPTH (DEPTH)
    ) u_ras_spec_stack (
        .clk            (clk),
        .rst            (rst),
        .spec_we        (spec_we),
        .spec_waddr     (spec_waddr),
        .spec_wdata     (spec_wdata),
        .rd_addr        (rd_addr),
        .rd_fire        (rd_fire),
        .stale_all      (stale_all),
        .commit_rdata   (commit_rdata),
        .commit_raddr   (commit_raddr),
        .predict_valid  (predict_valid),
        .predict_target (predict_target)
    );

    ras_commit_stack #(
        .DEPTH (DEPTH)
    ) u_ras_commit_stack (
        .clk               (clk),
        .rst               (rst),
        .commit_valid      (commit_valid),
        .commit_op         (commit_op),
        .commit_start_addr (commit_start_addr),
        .commit_offset     (commit_offset),
        .commit_raddr      (commit_raddr),
        .commit_top        (commit_top),
        .commit_count      (commit_count),
        .commit_rdata      (commit_rdata)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the return address stack testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ras_tb -Mdir obj_dir -f files.f

sim_out=$(./obj_dir/Vras_tb)
echo "$sim_out"

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
    exit 0
else
    exit 1
fi

//--- testbench/ras_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ras_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // reset drops on a rising edge once RESET_CYCLES edges have gone by
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/ras_ref_model.svh
`ifndef RAS_REF_MODEL_SVH
`define RAS_REF_MODEL_SVH

// speculative and committed pointer pairs with their storage
int              m_top;
int              m_count;
int              m_ctop;
int              m_ccount;
bpu_pkg::vaddr_t m_mem [DEPTH];
bpu_pkg::vaddr_t m_cmem [DEPTH];
bit              m_stale [DEPTH];

// prediction the DUT should show after the coming edge
bit              exp_valid;
bpu_pkg::vaddr_t exp_target;

function automatic int below(input int idx);
    return (idx == 0) ? DEPTH - 1 : idx - 1;
endfunction

// a call returns to the instruction right after it
function automatic bpu_pkg::vaddr_t ret_of(input bpu_pkg::vaddr_t start, input int offset);
    return start + bpu_pkg::vaddr_t'(offset * 4 + bpu_pkg::RET_STEP);
endfunction

function automatic bit has_write(input ras_pkg::ras_op_e op);
    return (op == ras_pkg::op_push) || (op == ras_pkg::op_pop_push);
endfunction

// pop_push rewrites the entry it pops, push fills the slot at top
function automatic int write_slot(input int top, input ras_pkg::ras_op_e op);
    return (op == ras_pkg::op_pop_push) ? below(top) : top;
endfunction

task automatic step_ptrs(inout int top, inout int count, input ras_pkg::ras_op_e op);
    if (op == ras_pkg::op_push) begin
        top   = (top + 1) % DEPTH;
        count = (count < DEPTH) ? count + 1 : DEPTH;
    end else if (op == ras_pkg::op_pop && count > 0) begin
        top   = below(top);
        count = count - 1;
    end
endtask

task automatic model_reset();
    m_top      = 0;
    m_count    = 0;
    m_ctop     = 0;
    m_ccount   = 0;
    exp_valid  = 1'b0;
    exp_target = '0;
    for (int i = 0; i < DEPTH; i++) begin
        m_mem[i]   = '0;
        m_cmem[i]  = '0;
        m_stale[i] = 1'b0;
    end
endtask

// one clock edge, taking the inputs as they are currently driven
task automatic model_clock_edge();
    int slot;
    exp_valid = 1'b0;
    if (flush) begin
        m_top   = m_ctop;
        m_count = m_ccount;
        for (int i = 0; i < DEPTH; i++) begin
            m_stale[i] = 1'b1;
        end
    end else if (squash_valid) begin
        m_top   = int'(squash_top);
        m_count = int'(squash_count);
        if (has_write(squash_op)) begin
            slot          = write_slot(m_top, squash_op);
            m_mem[slot]   = ret_of(squash_start_addr, int'(squash_offset));
            m_stale[slot] = 1'b0;
        end
        step_ptrs(m_top, m_count, squash_op);
    end else if (req_valid) begin
        if ((req_op == ras_pkg::op_pop || req_op == ras_pkg::op_pop_push) && m_count > 0) begin
            slot       = below(m_top);
            exp_valid  = 1'b1;
            exp_target = m_stale[slot] ? m_cmem[slot] : m_mem[slot];
        end
        if (has_write(req_op)) begin
            slot          = write_slot(m_top, req_op);
            m_mem[slot]   = req_target;
            m_stale[slot] = 1'b0;
        end
        step_ptrs(m_top, m_count, req_op);
    end
    // the commit side moves on its own, after the reads above saw its old state
    if (commit_valid) begin
        if (has_write(commit_op)) begin
            m_cmem[write_slot(m_ctop, commit_op)] =
                ret_of(commit_start_addr, int'(commit_offset));
        end
        step_ptrs(m_ctop, m_ccount, commit_op);
    end
endtask

`endif

//--- testbench/ras_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ras_tb;

    localparam int DEPTH       = 8;
    localparam int IDX_W       = $clog2(DEPTH);
    localparam int CNT_W       = $clog2(DEPTH + 1);
    localparam int OFF_W       = bpu_pkg::OFFSET_WIDTH;
    localparam int RAND_CYCLES = 2000;
    localparam int DIR_CYCLES  = 100;
    // reset, directed and random cycles at 40 ns each, plus slack
    localparam int WATCHDOG_NS = (2 + DIR_CYCLES + RAND_CYCLES + 100) * 40;

    logic                   clk;
    logic                   rst;
    logic                   req_valid;
    ras_pkg::ras_op_e       req_op;
    bpu_pkg::vaddr_t        req_target;
    logic                   squash_valid;
    ras_pkg::ras_op_e       squash_op;
    logic [IDX_W-1:0]       squash_top;
    logic [CNT_W-1:0]       squash_count;
    bpu_pkg::vaddr_t        squash_start_addr;
    logic [OFF_W-1:0]       squash_offset;
    logic                   flush;
    logic                   commit_valid;
    ras_pkg::ras_op_e       commit_op;
    bpu_pkg::vaddr_t        commit_start_addr;
    logic [OFF_W-1:0]       commit_offset;
    logic [IDX_W-1:0]       ckpt_top;
    logic [CNT_W-1:0]       ckpt_count;
    logic                   not_empty;
    logic                   predict_valid;
    bpu_pkg::vaddr_t        predict_target;

    int seed;
    int err_count;
    int tests_run;
    int tests_failed;
    int test_errs;
    int hist_wr;
    int hist_top [8];
    int hist_count [8];
    int saved_top;
    int saved_count;

    `include "ras_ref_model.svh"

    ras_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (2)
    ) u_ras_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    ras_top #(
        .DEPTH (DEPTH)
    ) u_ras_top (
        .clk               (clk),
        .rst               (rst),
        .req_valid         (req_valid),
        .req_op            (req_op),
        .req_target        (req_target),
        .squash_valid      (squash_valid),
        .squash_op         (squash_op),
        .squash_top        (squash_top),
        .squash_count      (squash_count),
        .squash_start_addr (squash_start_addr),
        .squash_offset     (squash_offset),
        .flush             (flush),
        .commit_valid      (commit_valid),
        .commit_op         (commit_op),
        .commit_start_addr (commit_start_addr),
        .commit_offset     (commit_offset),
        .ckpt_top          (ckpt_top),
        .ckpt_count        (ckpt_count),
        .not_empty         (not_empty),
        .predict_valid     (predict_valid),
        .predict_target    (predict_target)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cycle helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic idle_inputs();
        req_valid    <= 1'b0;
        squash_valid <= 1'b0;
        flush        <= 1'b0;
        commit_valid <= 1'b0;
    endtask

    // outputs are settled at the falling edge, then the model takes the coming edge
    task automatic end_cycle();
        @(negedge clk);
        assert (ckpt_top == IDX_W'(m_top) && ckpt_count == CNT_W'(m_count)
                && not_empty == (m_count != 0)) else begin
            $display("Fail %0t ns: checkpoint %0d/%0d not_empty %b, expected %0d/%0d",
                     $time, ckpt_top, ckpt_count, not_empty, m_top, m_count);
            err_count++;
        end
        assert (predict_valid == exp_valid) else begin
            $display("Fail %0t ns: predict_valid %b, expected %b", $time, predict_valid,
                     exp_valid);
            err_count++;
        end
        assert (!exp_valid || predict_target == exp_target) else begin
            $display("Fail %0t ns: predict_target %h, expected %h", $time, predict_target,
                     exp_target);
            err_count++;
        end
        model_clock_edge();
    endtask

    task automatic lookup(input ras_pkg::ras_op_e op, input bpu_pkg::vaddr_t target);
        @(posedge clk);
        idle_inputs();
        req_valid  <= 1'b1;
        req_op     <= op;
        req_target <= target;
        end_cycle();
    endtask

    task automatic retire(input ras_pkg::ras_op_e op, input bpu_pkg::vaddr_t start,
                          input int offset);
        @(posedge clk);
        idle_inputs();
        commit_valid      <= 1'b1;
        commit_op         <= op;
        commit_start_addr <= start;
        commit_offset     <= OFF_W'(offset);
        end_cycle();
    endtask

    task automatic squash_to(input ras_pkg::ras_op_e op, input int top, input int count,
                             input bpu_pkg::vaddr_t start, input int offset);
        @(posedge clk);
        idle_inputs();
        squash_valid      <= 1'b1;
        squash_op         <= op;
        squash_top        <= IDX_W'(top);
        squash_count      <= CNT_W'(count);
        squash_start_addr <= start;
        squash_offset     <= OFF_W'(offset);
        end_cycle();
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        idle_inputs();
        end_cycle();
    endtask

    // flush, squash, lookup and commit are drawn on their own, so they also collide
    task automatic random_cycle();
        int slot;
        @(posedge clk);
        hist_top[hist_wr]   = m_top;
        hist_count[hist_wr] = m_count;
        hist_wr             = (hist_wr + 1) % 8;
        slot                = $random(seed) & 7;
        flush             <= (($random(seed) & 63) == 0);
        squash_valid      <= (($random(seed) & 7) == 0);
        squash_op         <= ras_pkg::ras_op_e'(2'($random(seed)));
        squash_top        <= IDX_W'(hist_top[slot]);
        squash_count      <= CNT_W'(hist_count[slot]);
        squash_start_addr <= bpu_pkg::vaddr_t'($random(seed));
        squash_offset     <= OFF_W'($random(seed));
        req_valid         <= (($random(seed) & 3) != 0);
        req_op            <= ras_pkg::ras_op_e'(2'($random(seed)));
        req_target        <= bpu_pkg::vaddr_t'($random(seed));
        commit_valid      <= (($random(seed) & 3) == 0);
        commit_op         <= ras_pkg::ras_op_e'(2'($random(seed)));
        commit_start_addr <= bpu_pkg::vaddr_t'($random(seed));
        commit_offset     <= OFF_W'($random(seed));
        end_cycle();
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (err_count != test_errs) begin
            tests_failed++;
        end
        $display("test %-16s %s, %0d errors", name,
                 (err_count == test_errs) ? "ok" : "failed", err_count - test_errs);
        test_errs = err_count;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        seed              = 54;
        err_count         = 0;
        tests_run         = 0;
        tests_failed      = 0;
        test_errs         = 0;
        hist_wr           = 0;
        req_valid         = 1'b0;
        req_op            = ras_pkg::op_none;
        req_target        = '0;
        squash_valid      = 1'b0;
        squash_op         = ras_pkg::op_none;
        squash_top        = '0;
        squash_count      = '0;
        squash_start_addr = '0;
        squash_offset     = '0;
        flush             = 1'b0;
        commit_valid      = 1'b0;
        commit_op         = ras_pkg::op_none;
        commit_start_addr = '0;
        commit_offset     = '0;
        for (int i = 0; i < 8; i++) begin
            hist_top[i]   = 0;
            hist_count[i] = 0;
        end
        model_reset();
        @(negedge rst);

        // filling every slot here also means later reads never hit unwritten storage
        for (int i = 0; i < DEPTH; i++) lookup(ras_pkg::op_push, 32'h1000 + i * 4);
        for (int i = 0; i < DEPTH; i++) lookup(ras_pkg::op_pop, '0);
        idle_cycle();
        report_test("lifo_order");

        for (int i = 0; i < DEPTH + 2; i++) lookup(ras_pkg::op_push, 32'h2000 + i * 8);
        for (int i = 0; i < DEPTH + 2; i++) lookup(ras_pkg::op_pop, '0);
        idle_cycle();
        report_test("overflow_empty");

        lookup(ras_pkg::op_push, 32'h100);
        lookup(ras_pkg::op_push, 32'h200);
        lookup(ras_pkg::op_push, 32'h300);
        // state ahead of the third push, as a fetch stage would have kept it
        saved_top   = ckpt_top;
        saved_count = ckpt_count;
        lookup(ras_pkg::op_push, 32'h400);
        lookup(ras_pkg::op_pop, '0);
        squash_to(ras_pkg::op_push, saved_top, saved_count, 32'h1000, 3);
        for (int i = 0; i < 3; i++) lookup(ras_pkg::op_pop, '0);
        idle_cycle();
        report_test("squash_repair");

        // wrap the commit stack so every committed slot holds a real address
        for (int i = 0; i < DEPTH + 2; i++) retire(ras_pkg::op_push, 32'h4000 + i * 'h40, i);
        for (int i = 0; i < 3; i++) retire(ras_pkg::op_pop, '0, 0);
        lookup(ras_pkg::op_push, 32'hdead0);
        lookup(ras_pkg::op_push, 32'hdead8);
        @(posedge clk);
        idle_inputs();
        flush <= 1'b1;
        end_cycle();
        lookup(ras_pkg::op_pop, '0);
        lookup(ras_pkg::op_pop, '0);
        lookup(ras_pkg::op_push, 32'h7770);
        lookup(ras_pkg::op_pop, '0);
        lookup(ras_pkg::op_pop, '0);
        idle_cycle();
        report_test("flush_stale");

        for (int i = 0; i < RAND_CYCLES; i++) random_cycle();
        idle_cycle();
        idle_cycle();
        report_test("random_mix");

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
